//--- design/coreTop.sv
// One instruction in flight, retired 3 cycles after acceptance, and no new fetch after halted or illegal.
module coreTop #(
    parameter logic [rvPkg::XLEN-1:0] ResetPc   = '0,
    parameter int unsigned            DmemWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic        instrValid,
    output logic        instrReady,
    output logic        wbValid,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData,
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic        halted,
    output logic        illegal
);
    import rvPkg::*;

    // one-hot: decode, execute, commit
    logic [2:0]      stage;
    logic            accept;
    logic            load;
    logic            commit;
    logic [XLEN-1:0] pc;
    logic [31:0]     instrReg;
    logic [4:0]      rs1Addr;
    logic [4:0]      rs2Addr;
    logic [31:0]     rs1Data;
    logic [31:0]     rs2Data;
    decodedT         decoded;
    execT            exec;
    logic            wrEn;
    logic [4:0]      wrAddr;
    logic [31:0]     wrData;

    assign instrReady = ~(|stage) & ~halted & ~illegal;
    assign accept     = instrValid & instrReady;
    assign load       = stage[0];
    assign commit     = stage[2];
    assign retirePc   = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else begin
            stage <= {stage[1:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instrReg <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= ResetPc;
            wbValid     <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            wbValid     <= wrEn;
            retireValid <= commit;
            if (commit) begin
                pc <= exec.nextPc;
            end
        end
    end

    // write-back trace follows the regfile write
    always_ff @(posedge clk) begin
        if (wrEn) begin
            wbAddr <= wrAddr;
            wbData <= wrData;
        end
    end

    ctrlGen uCtrlGen (
        .clk(clk), .reset(reset), .load(load), .instr(instrReg), .pc(pc),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .decoded(decoded)
    );

    regFile uRegFile (
        .clk(clk), .reset(reset), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    execUnit #(.ResetPc(ResetPc)) uExecUnit (
        .clk(clk), .reset(reset), .decoded(decoded), .exec(exec)
    );

    resultStage #(.DmemWords(DmemWords)) uResultStage (
        .clk(clk), .reset(reset), .exec(exec), .commit(commit),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .halted(halted), .illegal(illegal)
    );

endmodule

//--- design/ctrlGen.sv
// Every SYSTEM opcode is taken as ebreak, and M-extension encodings of OP are not flagged as illegal.
module ctrlGen (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  logic [31:0]    instr,
    input  logic [31:0]    pc,
    input  logic [31:0]    rs1Data,
    input  logic [31:0]    rs2Data,
    output logic [4:0]     rs1Addr,
    output logic [4:0]     rs2Addr,
    output rvPkg::decodedT decoded
);
    import rvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    extTypeE    extType;
    ctrlT       ctrl;
    logic [XLEN-1:0] imm;
    decodedT    decNext;

    assign opcode  = opcodeE'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    // control fields, defaults write nothing
    always_comb begin
        ctrl    = '0;
        extType = ExtN;
        case (opcode)
            OpReg: begin
                extType    = ExtR;
                ctrl.regWr = 1'b1;
                ctrl.aluOp = aluOpE'({instr[30], instr[25], funct3});
            end
            OpImm: begin
                extType    = ExtI;
                ctrl.regWr = 1'b1;
                ctrl.bSrc  = BSrcImm;
                // only srai carries funct7[5]
                if (funct3 == 3'b101 && instr[30]) begin
                    ctrl.aluOp = aluOpE'({2'b10, funct3});
                end else begin
                    ctrl.aluOp = aluOpE'({2'b00, funct3});
                end
            end
            OpLoad: begin
                extType       = ExtI;
                ctrl.regWr    = 1'b1;
                ctrl.bSrc     = BSrcImm;
                ctrl.memToReg = 1'b1;
                ctrl.memOp    = funct3;
            end
            OpStore: begin
                extType    = ExtS;
                ctrl.bSrc  = BSrcImm;
                ctrl.memWr = 1'b1;
                ctrl.memOp = funct3;
            end
            OpBranch: begin
                extType = ExtB;
                case (funct3)
                    3'b000: begin
                        ctrl.branch = BrEq;
                        ctrl.aluOp  = AluSlt;
                    end
                    3'b001: begin
                        ctrl.branch = BrNe;
                        ctrl.aluOp  = AluSlt;
                    end
                    3'b100: begin
                        ctrl.branch = BrLt;
                        ctrl.aluOp  = AluSlt;
                    end
                    3'b101: begin
                        ctrl.branch = BrGe;
                        ctrl.aluOp  = AluSlt;
                    end
                    3'b110: begin
                        ctrl.branch = BrLt;
                        ctrl.aluOp  = AluSltu;
                    end
                    3'b111: begin
                        ctrl.branch = BrGe;
                        ctrl.aluOp  = AluSltu;
                    end
                    default: ctrl.status = StError;
                endcase
            end
            OpJal, OpJalr: begin
                // link value pc+4 comes out of the ALU
                extType     = (opcode == OpJal) ? ExtJ : ExtI;
                ctrl.regWr  = 1'b1;
                ctrl.aSrc   = ASrcPc;
                ctrl.bSrc   = BSrcFour;
                ctrl.branch = (opcode == OpJal) ? BrJal : BrJalr;
            end
            OpLui: begin
                extType    = ExtU;
                ctrl.regWr = 1'b1;
                ctrl.bSrc  = BSrcImm;
                ctrl.aluOp = AluPassB;
            end
            OpAuipc: begin
                extType    = ExtU;
                ctrl.regWr = 1'b1;
                ctrl.aSrc  = ASrcPc;
                ctrl.bSrc  = BSrcImm;
            end
            OpSystem: begin
                extType     = ExtI;
                ctrl.status = StEbreak;
            end
            default: ctrl.status = StError;
        endcase
    end

    // immediate of the selected format
    always_comb begin
        case (extType)
            ExtI:    imm = {{20{instr[31]}}, instr[31:20]};
            ExtS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            ExtB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            ExtU:    imm = {instr[31:12], 12'b0};
            ExtJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        decNext.ctrl    = ctrl;
        decNext.rd      = instr[11:7];
        decNext.rs1Data = rs1Data;
        decNext.rs2Data = rs2Data;
        decNext.imm     = imm;
        decNext.pc      = pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.ctrl <= '0;
        end else if (load) begin
            decoded <= decNext;
        end
    end

endmodule

//--- design/execUnit.sv
// Registers a result every cycle, so decoded must stay stable for the cycle before commit.
module execUnit #(
    parameter logic [rvPkg::XLEN-1:0] ResetPc = '0
) (
    input  logic           clk,
    input  logic           reset,
    input  rvPkg::decodedT decoded,
    output rvPkg::execT    exec
);
    import rvPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] jalrTarget;
    logic            taken;
    execT            execNext;

    // operand select
    assign opA = (decoded.ctrl.aSrc == ASrcPc) ? decoded.pc : decoded.rs1Data;

    always_comb begin
        case (decoded.ctrl.bSrc)
            BSrcRs2:  opB = decoded.rs2Data;
            BSrcImm:  opB = decoded.imm;
            BSrcFour: opB = XLEN'(4);
            default:  opB = '0;
        endcase
    end

    // shifts use only the low 5 bits of B
    always_comb begin
        case (decoded.ctrl.aluOp)
            AluAdd:   aluResult = opA + opB;
            AluSub:   aluResult = opA - opB;
            AluSll:   aluResult = opA << opB[4:0];
            AluSlt:   aluResult = XLEN'($signed(opA) < $signed(opB));
            AluSltu:  aluResult = XLEN'(opA < opB);
            AluXor:   aluResult = opA ^ opB;
            AluSrl:   aluResult = opA >> opB[4:0];
            AluSra:   aluResult = $signed(opA) >>> opB[4:0];
            AluOr:    aluResult = opA | opB;
            AluAnd:   aluResult = opA & opB;
            AluPassB: aluResult = opB;
            default:  aluResult = opA + opB;
        endcase
    end

    assign pcPlus4    = decoded.pc + XLEN'(4);
    assign pcTarget   = decoded.pc + decoded.imm;
    assign jalrTarget = (decoded.rs1Data + decoded.imm) & ~XLEN'(1);

    // lt/ge reuse the slt or sltu result
    always_comb begin
        case (decoded.ctrl.branch)
            BrJal:   taken = 1'b1;
            BrJalr:  taken = 1'b1;
            BrEq:    taken = (opA == opB);
            BrNe:    taken = (opA != opB);
            BrLt:    taken = aluResult[0];
            BrGe:    taken = ~aluResult[0];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        execNext.ctrl      = decoded.ctrl;
        execNext.rd        = decoded.rd;
        execNext.aluResult = aluResult;
        execNext.storeData = decoded.rs2Data;
        if (!taken) begin
            execNext.nextPc = pcPlus4;
        end else if (decoded.ctrl.branch == BrJalr) begin
            execNext.nextPc = jalrTarget;
        end else begin
            execNext.nextPc = pcTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec.ctrl   <= '0;
            exec.nextPc <= ResetPc;
        end else begin
            exec <= execNext;
        end
    end

endmodule

//--- design/regFile.sv
// Reads are combinational, so a value written at one edge is visible to the next decode.
module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    always_comb begin
        if (rs1Addr == 5'd0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[rs1Addr];
        end
    end

    always_comb begin
        if (rs2Addr == 5'd0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[rs2Addr];
        end
    end

endmodule

//--- design/resultStage.sv
// DmemWords must be a power of two of at least 2, and a halfword access ignores address bit 0.
module resultStage #(
    parameter int unsigned DmemWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  rvPkg::execT exec,
    input  logic        commit,
    output logic        wrEn,
    output logic [4:0]  wrAddr,
    output logic [31:0] wrData,
    output logic        halted,
    output logic        illegal
);
    import rvPkg::*;

    localparam int AddrW = $clog2(DmemWords);

    logic [XLEN-1:0]  mem [DmemWords];
    logic [AddrW-1:0] wordIdx;
    logic [1:0]       byteOff;
    logic [1:0]       alignedOff;
    logic [3:0]       byteMask;
    logic [XLEN-1:0]  storeWord;
    logic [XLEN-1:0]  rdWord;
    logic [XLEN-1:0]  rdShifted;
    logic [XLEN-1:0]  loadData;

    // address wraps modulo the memory size
    assign wordIdx    = exec.aluResult[AddrW+1:2];
    assign byteOff    = exec.aluResult[1:0];
    assign alignedOff = exec.ctrl.memOp[0] ? {byteOff[1], 1'b0} : byteOff;

    always_comb begin
        case (exec.ctrl.memOp[1:0])
            2'b00: begin
                byteMask  = 4'b0001 << alignedOff;
                storeWord = {4{exec.storeData[7:0]}};
            end
            2'b01: begin
                byteMask  = 4'b0011 << alignedOff;
                storeWord = {2{exec.storeData[15:0]}};
            end
            2'b10: begin
                byteMask  = 4'b1111;
                storeWord = exec.storeData;
            end
            default: begin
                byteMask  = 4'b0000;
                storeWord = exec.storeData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (commit && exec.ctrl.memWr) begin
            for (int b = 0; b < 4; b++) begin
                if (byteMask[b]) begin
                    mem[wordIdx][b*8 +: 8] <= storeWord[b*8 +: 8];
                end
            end
        end
    end

    // load extract and extend
    assign rdWord    = mem[wordIdx];
    assign rdShifted = rdWord >> {alignedOff, 3'b000};

    always_comb begin
        case (exec.ctrl.memOp)
            3'b000:  loadData = {{24{rdShifted[7]}}, rdShifted[7:0]};
            3'b001:  loadData = {{16{rdShifted[15]}}, rdShifted[15:0]};
            3'b100:  loadData = {24'b0, rdShifted[7:0]};
            3'b101:  loadData = {16'b0, rdShifted[15:0]};
            default: loadData = rdWord;
        endcase
    end

    assign wrEn   = commit && exec.ctrl.regWr && (exec.rd != 5'd0);
    assign wrAddr = exec.rd;
    assign wrData = exec.ctrl.memToReg ? loadData : exec.aluResult;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (commit) begin
            if (exec.ctrl.status == StEbreak) begin
                halted <= 1'b1;
            end
            if (exec.ctrl.status == StError) begin
                illegal <= 1'b1;
            end
        end
    end

endmodule

//--- design/rvPkg.sv
// Shared RV32I types. aluOpE and branchE use core-internal codes that only this core decodes.
package rvPkg;

    localparam int XLEN = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpSystem = 7'b1110011
    } opcodeE;

    // immediate formats, ExtN marks an unknown instruction
    typedef enum logic [2:0] {
        ExtI = 3'b000,
        ExtU = 3'b001,
        ExtS = 3'b010,
        ExtB = 3'b011,
        ExtJ = 3'b100,
        ExtN = 3'b101,
        ExtR = 3'b111
    } extTypeE;

    // {funct7[5], funct7[0], funct3}
    typedef enum logic [4:0] {
        AluAdd   = 5'b00000,
        AluSll   = 5'b00001,
        AluSlt   = 5'b00010,
        AluSltu  = 5'b00011,
        AluXor   = 5'b00100,
        AluSrl   = 5'b00101,
        AluOr    = 5'b00110,
        AluAnd   = 5'b00111,
        AluSub   = 5'b10000,
        AluSra   = 5'b10101,
        AluPassB = 5'b11000
    } aluOpE;

    // signedness of lt/ge comes from aluOp (slt or sltu)
    typedef enum logic [2:0] {
        BrNone = 3'b000,
        BrJal  = 3'b001,
        BrJalr = 3'b010,
        BrEq   = 3'b100,
        BrNe   = 3'b101,
        BrLt   = 3'b110,
        BrGe   = 3'b111
    } branchE;

    typedef enum logic {
        ASrcRs1 = 1'b0,
        ASrcPc  = 1'b1
    } aSrcE;

    typedef enum logic [1:0] {
        BSrcRs2  = 2'b00,
        BSrcImm  = 2'b01,
        BSrcFour = 2'b10
    } bSrcE;

    typedef enum logic [1:0] {
        StRunning = 2'b00,
        StError   = 2'b01,
        StEbreak  = 2'b10
    } instStatusE;

    typedef struct packed {
        logic       regWr;
        aSrcE       aSrc;
        bSrcE       bSrc;
        aluOpE      aluOp;
        branchE     branch;
        logic       memToReg;
        logic       memWr;
        logic [2:0] memOp;
        instStatusE status;
    } ctrlT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] rs1Data;
        logic [XLEN-1:0] rs2Data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
    } decodedT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] storeData;
        logic [XLEN-1:0] nextPc;
    } execT;

endpackage

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module coreTb \
    && ./obj_dir/VcoreTb | tee /dev/stderr | grep -qx "sim passed" \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

//--- tb.f
design/rvPkg.sv
design/ctrlGen.sv
design/regFile.sv
design/execUnit.sv
design/resultStage.sv
design/coreTop.sv
test/coreTb_assert.sv
test/coreTb.sv

//--- test/coreTb.sv
// Feeds coreTop from a fixed program table; a branch only moves the PC, the next row is always next.
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] ResetPc        = 32'h0;
    localparam int          ResetCycles    = 10;
    localparam int          CyclesPerInstr = 4;
    localparam int          HaltWaitCycles = 8;
    localparam int          DriveDelay     = 2;

    // RV32I major opcodes
    localparam logic [6:0] OpcR      = 7'h33;
    localparam logic [6:0] OpcI      = 7'h13;
    localparam logic [6:0] OpcLoad   = 7'h03;
    localparam logic [6:0] OpcStore  = 7'h23;
    localparam logic [6:0] OpcBranch = 7'h63;
    localparam logic [6:0] OpcJal    = 7'h6F;
    localparam logic [6:0] OpcJalr   = 7'h67;
    localparam logic [6:0] OpcLui    = 7'h37;
    localparam logic [6:0] OpcAuipc  = 7'h17;

    typedef struct packed {
        logic [31:0] instr;
        logic        wbValid;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
        logic [31:0] nextPc;
    } rowT;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instrValid;
    logic        instrReady;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        retireValid;
    logic [31:0] retirePc;
    logic        halted;
    logic        illegal;

    rowT         rows[$];
    string       names[$];
    logic [31:0] pcNow;
    logic        tableBuilt = 1'b0;

    coreTop #(.ResetPc(ResetPc), .DmemWords(256)) DUT (
        .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .instrReady(instrReady), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .retireValid(retireValid), .retirePc(retirePc), .halted(halted), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders, field layout from the RV32I spec
    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpcR};
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OpcStore};
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OpcBranch};
    endfunction

    function automatic logic [31:0] encU(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OpcJal};
    endfunction

    task automatic addRow(string name, logic [31:0] ins, int wbV, int rd, logic [31:0] data,
                          logic [31:0] npc);
        rowT row;
        row.instr   = ins;
        row.wbValid = wbV[0];
        row.wbAddr  = rd[4:0];
        row.wbData  = data;
        row.nextPc  = npc;
        rows.push_back(row);
        names.push_back(name);
        pcNow = npc;
    endtask

    // x1 = -5 and x2 = 3 are the operands for most rows
    task automatic buildTable();
        pcNow = ResetPc;
        addRow("addi neg", encI(-5, 0, 0, 1, OpcI), 1, 1, 32'hFFFFFFFB, pcNow + 4);
        addRow("addi pos", encI(3, 0, 0, 2, OpcI), 1, 2, 32'h3, pcNow + 4);
        addRow("add", encR(0, 2, 1, 0, 3), 1, 3, 32'hFFFFFFFE, pcNow + 4);
        addRow("sub", encR('h20, 1, 2, 0, 4), 1, 4, 32'h8, pcNow + 4);
        addRow("slt", encR(0, 2, 1, 2, 5), 1, 5, 32'h1, pcNow + 4);
        addRow("sltu", encR(0, 2, 1, 3, 6), 1, 6, 32'h0, pcNow + 4);
        addRow("xor", encR(0, 2, 1, 4, 7), 1, 7, 32'hFFFFFFF8, pcNow + 4);
        addRow("sll", encR(0, 2, 2, 1, 8), 1, 8, 32'h18, pcNow + 4);
        addRow("srl", encR(0, 2, 1, 5, 9), 1, 9, 32'h1FFFFFFF, pcNow + 4);
        addRow("sra", encR('h20, 2, 1, 5, 10), 1, 10, 32'hFFFFFFFF, pcNow + 4);
        addRow("srai", encI('h401, 1, 5, 11, OpcI), 1, 11, 32'hFFFFFFFD, pcNow + 4);
        addRow("lui", encU('h12345, 12, OpcLui), 1, 12, 32'h12345000, pcNow + 4);
        addRow("auipc", encU('h1, 13, OpcAuipc), 1, 13, pcNow + 32'h1000, pcNow + 4);
        // x14 is the data base address, x15 the store pattern
        addRow("addi base", encI('h40, 0, 0, 14, OpcI), 1, 14, 32'h40, pcNow + 4);
        addRow("lui data", encU('h89ABD, 15, OpcLui), 1, 15, 32'h89ABD000, pcNow + 4);
        addRow("addi data", encI(-'h211, 15, 0, 15, OpcI), 1, 15, 32'h89ABCDEF, pcNow + 4);
        addRow("sw", encS(0, 15, 14, 2), 0, 0, 32'h0, pcNow + 4);
        addRow("lw", encI(0, 14, 2, 16, OpcLoad), 1, 16, 32'h89ABCDEF, pcNow + 4);
        addRow("lb off1", encI(1, 14, 0, 17, OpcLoad), 1, 17, 32'hFFFFFFCD, pcNow + 4);
        addRow("lbu off3", encI(3, 14, 4, 18, OpcLoad), 1, 18, 32'h00000089, pcNow + 4);
        addRow("lh off2", encI(2, 14, 1, 19, OpcLoad), 1, 19, 32'hFFFF89AB, pcNow + 4);
        addRow("lhu off0", encI(0, 14, 5, 20, OpcLoad), 1, 20, 32'h0000CDEF, pcNow + 4);
        addRow("sh off2", encS(2, 2, 14, 1), 0, 0, 32'h0, pcNow + 4);
        addRow("sb off1", encS(1, 1, 14, 0), 0, 0, 32'h0, pcNow + 4);
        addRow("lw merged", encI(0, 14, 2, 21, OpcLoad), 1, 21, 32'h0003FBEF, pcNow + 4);
        addRow("lh neg", encI(0, 14, 1, 22, OpcLoad), 1, 22, 32'hFFFFFBEF, pcNow + 4);
        addRow("sb off5", encS(5, 1, 14, 0), 0, 0, 32'h0, pcNow + 4);
        addRow("lbu off5", encI(5, 14, 4, 23, OpcLoad), 1, 23, 32'h000000FB, pcNow + 4);
        addRow("lb off5", encI(5, 14, 0, 24, OpcLoad), 1, 24, 32'hFFFFFFFB, pcNow + 4);
        addRow("beq taken", encB(16, 2, 2, 0), 0, 0, 32'h0, pcNow + 16);
        addRow("beq not taken", encB(16, 2, 1, 0), 0, 0, 32'h0, pcNow + 4);
        addRow("bne taken back", encB(-8, 2, 1, 1), 0, 0, 32'h0, pcNow - 8);
        addRow("bne not taken", encB(12, 2, 2, 1), 0, 0, 32'h0, pcNow + 4);
        addRow("blt taken", encB(12, 2, 1, 4), 0, 0, 32'h0, pcNow + 12);
        addRow("blt not taken", encB(12, 1, 2, 4), 0, 0, 32'h0, pcNow + 4);
        addRow("bgeu taken", encB(20, 2, 1, 7), 0, 0, 32'h0, pcNow + 20);
        addRow("bgeu not taken", encB(20, 1, 2, 7), 0, 0, 32'h0, pcNow + 4);
        addRow("jal", encJ(32, 25), 1, 25, pcNow + 4, pcNow + 32);
        // 0x40 + 0x41 with bit 0 cleared
        addRow("jalr", encI('h41, 14, 0, 26, OpcJalr), 1, 26, pcNow + 4, 32'h80);
        addRow("addi x0", encI(7, 2, 0, 0, OpcI), 0, 0, 32'h0, pcNow + 4);
        addRow("read x0", encR(0, 0, 2, 0, 27), 1, 27, 32'h3, pcNow + 4);
        addRow("ebreak", 32'h00100073, 0, 0, 32'h0, pcNow + 4);
    endtask

    task automatic checkVal(string testName, string field, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("error %s %s: expected %h actual %h", testName, field, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;
    endtask

    task automatic issue(logic [31:0] word);
        while (!instrReady) begin
            @(posedge clk);
            #DriveDelay;
        end
        instr      = word;
        instrValid = 1'b1;
        @(posedge clk);
        #DriveDelay;
        instrValid = 1'b0;
        instr      = '0;
    endtask

    task automatic waitRetire();
        while (!retireValid) begin
            @(posedge clk);
            #DriveDelay;
        end
    endtask

    task automatic runRow(int i);
        issue(rows[i].instr);
        waitRetire();
        checkVal(names[i], "wbValid", 32'(rows[i].wbValid), 32'(wbValid));
        if (rows[i].wbValid) begin
            checkVal(names[i], "wbAddr", 32'(rows[i].wbAddr), 32'(wbAddr));
            checkVal(names[i], "wbData", rows[i].wbData, wbData);
        end
        checkVal(names[i], "retirePc", rows[i].nextPc, retirePc);
    endtask

    initial begin
        int limit;
        wait (tableBuilt);
        limit = (rows.size() + 2) * CyclesPerInstr + 2 * ResetCycles + HaltWaitCycles + 20;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the core stopped responding", limit);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        instr      = '0;
        instrValid = 1'b0;
        reset      = 1'b1;
        buildTable();
        tableBuilt = 1'b1;
        applyReset();
        for (int i = 0; i < rows.size(); i++) begin
            runRow(i);
        end

        // core must refuse everything after ebreak
        checkVal("ebreak", "halted", 32'h1, 32'(halted));
        instr      = encI(1, 0, 0, 1, OpcI);
        instrValid = 1'b1;
        repeat (HaltWaitCycles) begin
            @(posedge clk);
            #DriveDelay;
            checkVal("ebreak", "instrReady", 32'h0, 32'(instrReady));
            checkVal("ebreak", "retireValid", 32'h0, 32'(retireValid));
        end
        instrValid = 1'b0;
        instr      = '0;

        applyReset();
        checkVal("after reset", "instrReady", 32'h1, 32'(instrReady));
        checkVal("after reset", "halted", 32'h0, 32'(halted));
        checkVal("after reset", "illegal", 32'h0, 32'(illegal));
        checkVal("after reset", "retirePc", ResetPc, retirePc);

        // opcode 7'h7f is not RV32I
        issue(32'hFFFFFFFF);
        waitRetire();
        checkVal("illegal", "wbValid", 32'h0, 32'(wbValid));
        checkVal("illegal", "illegal", 32'h1, 32'(illegal));
        checkVal("illegal", "retirePc", ResetPc + 4, retirePc);
        checkVal("illegal", "instrReady", 32'h0, 32'(instrReady));

        $display("sim passed");
        $finish;
    end

endmodule

//--- test/coreTb_assert.sv
// Bound into coreTop; the latency checks assume one instruction in flight with a fixed 3-cycle retire.
module coreProtocolAssert (
    input logic       clk,
    input logic       reset,
    input logic       instrValid,
    input logic       instrReady,
    input logic       retireValid,
    input logic       wbValid,
    input logic [4:0] wbAddr,
    input logic       halted
);
    timeunit 1ns;
    timeprecision 100ps;

    logic accept;

    assign accept = instrValid && instrReady;

    // busy for the three edges that follow an acceptance
    readyLowAfterAccept: assert property (@(posedge clk) disable iff (reset)
        ($past(accept, 1) || $past(accept, 2) || $past(accept, 3)) |-> !instrReady)
        else $error("instrReady rose within three cycles of an acceptance");

    // accept is sampled before edge 0, retireValid is registered at edge 3
    retireLatency: assert property (@(posedge clk) disable iff (reset)
        retireValid == $past(accept, 4))
        else $error("retireValid does not follow an acceptance by three cycles");

    noWriteToX0: assert property (@(posedge clk) disable iff (reset)
        wbValid |-> wbAddr != 5'd0)
        else $error("wbValid reported a write to x0");

    haltedSticky: assert property (@(posedge clk) disable iff (reset)
        !$fell(halted))
        else $error("halted fell while reset was low");

endmodule

bind coreTop coreProtocolAssert uProtocolAssert (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .instrReady(instrReady),
    .retireValid(retireValid),
    .wbValid(wbValid),
    .wbAddr(wbAddr),
    .halted(halted)
);
